// ==== Bender.yml ====
package:
  name: engine_pipeline

sources:
  - src/engine_pipeline_pkg.sv
  - src/packet_fifo.sv
  - src/hyper_pipeline.sv
  - src/engine_lane.sv
  - src/engine_status.sv
  - src/engine_pipeline.sv
  - target: test
    files:
      - tb/engine_pipeline_assertions.sv
      - tb/tb_engine_pipeline.sv

// ==== build.f ====
src/engine_pipeline_pkg.sv
src/packet_fifo.sv
src/hyper_pipeline.sv
src/engine_lane.sv
src/engine_status.sv
src/engine_pipeline.sv
tb/engine_pipeline_assertions.sv
tb/tb_engine_pipeline.sv

// ==== src/engine_lane.sv ====
/*
 * Engine lane
 * Input FIFO, register pipeline and output FIFO for one packet channel
 */
`timescale 1ns/1ps

module engine_lane #(
    parameter int width = $bits(engine_pipeline_pkg::engine_packet_t)
) (
    input  logic             ap_clk,
    input  logic             areset_template_engine,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_packet,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_packet,
    output logic             lane_idle
);

    logic             head_valid;
    logic [width-1:0] head_packet;
    logic             in_empty;
    logic             pop_enable;
    logic             pipe_valid;
    logic [width-1:0] pipe_packet;
    logic             pipe_busy;
    logic             out_empty;
    logic             out_prog_full;

    // ------------------------------
    // Input side
    // ------------------------------
    // Pop only while the output FIFO has headroom
    assign pop_enable = ~out_prog_full;

    packet_fifo #(
        .width(width)
    ) u_in_fifo (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .in_valid               (in_valid),
        .in_ready               (in_ready),
        .in_packet              (in_packet),
        .out_valid              (head_valid),
        .out_ready              (pop_enable),
        .out_packet             (head_packet),
        .empty                  (in_empty),
        .prog_full              ()
    );

    hyper_pipeline #(
        .width(width)
    ) u_pipeline (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .in_valid               (head_valid & pop_enable),
        .in_packet              (head_packet),
        .out_valid              (pipe_valid),
        .out_packet             (pipe_packet),
        .busy                   (pipe_busy)
    );

    // ------------------------------
    // Output side
    // ------------------------------
    // Pipeline pushes straight in, threshold guarantees space
    packet_fifo #(
        .width(width)
    ) u_out_fifo (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .in_valid               (pipe_valid),
        .in_ready               (),
        .in_packet              (pipe_packet),
        .out_valid              (out_valid),
        .out_ready              (out_ready),
        .out_packet             (out_packet),
        .empty                  (out_empty),
        .prog_full              (out_prog_full)
    );

    assign lane_idle = in_empty & out_empty & ~pipe_busy;

endmodule

// ==== src/engine_pipeline.sv ====
/*
 * Engine pipeline top level
 * Engine and memory response channels passed through to request streams
 */
`timescale 1ns/1ps

module engine_pipeline (
    input  logic                                ap_clk,
    input  logic                                areset_template_engine,
    input  logic                                descriptor_valid,
    input  logic                                response_engine_valid,
    output logic                                response_engine_ready,
    input  engine_pipeline_pkg::engine_packet_t response_engine_packet,
    input  logic                                response_memory_valid,
    output logic                                response_memory_ready,
    input  engine_pipeline_pkg::memory_packet_t response_memory_packet,
    output logic                                request_engine_valid,
    input  logic                                request_engine_ready,
    output engine_pipeline_pkg::engine_packet_t request_engine_packet,
    output logic                                request_memory_valid,
    input  logic                                request_memory_ready,
    output engine_pipeline_pkg::memory_packet_t request_memory_packet,
    output logic                                done
);

    logic [1:0] lanes_idle;
    logic       work_accepted;

    // Any inbound beat this cycle
    assign work_accepted = (response_engine_valid & response_engine_ready)
                         | (response_memory_valid & response_memory_ready);

    // ------------------------------
    // Channel lanes
    // ------------------------------
    engine_lane #(
        .width($bits(engine_pipeline_pkg::engine_packet_t))
    ) u_engine_lane (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .in_valid               (response_engine_valid),
        .in_ready               (response_engine_ready),
        .in_packet              (response_engine_packet),
        .out_valid              (request_engine_valid),
        .out_ready              (request_engine_ready),
        .out_packet             (request_engine_packet),
        .lane_idle              (lanes_idle[0])
    );

    engine_lane #(
        .width($bits(engine_pipeline_pkg::memory_packet_t))
    ) u_memory_lane (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .in_valid               (response_memory_valid),
        .in_ready               (response_memory_ready),
        .in_packet              (response_memory_packet),
        .out_valid              (request_memory_valid),
        .out_ready              (request_memory_ready),
        .out_packet             (request_memory_packet),
        .lane_idle              (lanes_idle[1])
    );

    // Done tracking
    engine_status u_status (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .descriptor_valid       (descriptor_valid),
        .lanes_idle             (lanes_idle),
        .work_accepted          (work_accepted),
        .done                   (done)
    );

endmodule

// ==== src/engine_pipeline_pkg.sv ====
/*
 * Engine pipeline shared types
 * Field widths, lane sizing, packet structs and the run-state encoding
 */
package engine_pipeline_pkg;

    // ------------------------------
    // Packet field widths
    // ------------------------------
    localparam int engine_id_width   = 8;
    localparam int packet_data_width = 32;
    localparam int memory_addr_width = 16;

    // ------------------------------
    // Lane sizing
    // ------------------------------
    localparam int lane_fifo_depth      = 16;
    // Leaves room for words still in the pipeline
    localparam int lane_prog_thresh     = 8;
    localparam int lane_pipeline_stages = 2;

    // Vertex/engine traffic, 40 bits
    typedef struct packed {
        logic [engine_id_width-1:0]   id;
        logic [packet_data_width-1:0] data;
    } engine_packet_t;

    // Memory traffic, 48 bits
    typedef struct packed {
        logic [memory_addr_width-1:0] addr;
        logic [packet_data_width-1:0] data;
    } memory_packet_t;

    // Kernel run state
    typedef enum logic [1:0] {
        state_idle    = 2'd0,
        state_running = 2'd1,
        state_done    = 2'd2
    } run_state_t;

endpackage

// ==== src/engine_status.sv ====
/*
 * Engine status
 * Run-state machine raising done once both lanes have drained
 */
`timescale 1ns/1ps

module engine_status (
    input  logic       ap_clk,
    input  logic       areset_template_engine,
    input  logic       descriptor_valid,
    input  logic [1:0] lanes_idle,
    input  logic       work_accepted,
    output logic       done
);

    engine_pipeline_pkg::run_state_t state;
    engine_pipeline_pkg::run_state_t state_next;
    logic                            lanes_drained;

    // Both lanes empty and nothing new this cycle
    assign lanes_drained = (&lanes_idle) & ~work_accepted;

    always_comb begin
        state_next = state;
        case (state)
            engine_pipeline_pkg::state_idle: begin
                if (descriptor_valid) begin
                    state_next = engine_pipeline_pkg::state_running;
                end
            end
            engine_pipeline_pkg::state_running: begin
                if (lanes_drained) begin
                    state_next = engine_pipeline_pkg::state_done;
                end
            end
            engine_pipeline_pkg::state_done: begin
                // New work or a new kernel reopens the run
                if (work_accepted || descriptor_valid) begin
                    state_next = engine_pipeline_pkg::state_running;
                end
            end
            default: state_next = engine_pipeline_pkg::state_idle;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            state <= engine_pipeline_pkg::state_idle;
            done  <= 1'b0;
        end else begin
            state <= state_next;
            done  <= (state == engine_pipeline_pkg::state_done);
        end
    end

endmodule

// ==== src/hyper_pipeline.sv ====
/*
 * Hyper pipeline
 * Free-running register chain for a valid bit and its payload
 */
`timescale 1ns/1ps

module hyper_pipeline #(
    parameter int width  = $bits(engine_pipeline_pkg::engine_packet_t),
    parameter int stages = engine_pipeline_pkg::lane_pipeline_stages
) (
    input  logic             ap_clk,
    input  logic             areset_template_engine,
    input  logic             in_valid,
    input  logic [width-1:0] in_packet,
    output logic             out_valid,
    output logic [width-1:0] out_packet,
    output logic             busy
);

    logic [stages-1:0] valid_q;
    logic [width-1:0]  data_q [stages];

    // Valid chain, no stall
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < stages; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Payload chain
    always_ff @(posedge ap_clk) begin
        data_q[0] <= in_packet;
        for (int i = 1; i < stages; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid  = valid_q[stages-1];
    assign out_packet = data_q[stages-1];
    // Anything still in flight
    assign busy       = |valid_q;

endmodule

// ==== src/packet_fifo.sv ====
/*
 * Packet FIFO
 * Synchronous first-word-fall-through buffer with empty and programmable-full
 */
`timescale 1ns/1ps

module packet_fifo #(
    parameter int width       = $bits(engine_pipeline_pkg::engine_packet_t),
    parameter int depth       = engine_pipeline_pkg::lane_fifo_depth,
    parameter int prog_thresh = engine_pipeline_pkg::lane_prog_thresh
) (
    input  logic             ap_clk,
    input  logic             areset_template_engine,
    input  logic             in_valid,
    output logic             in_ready,
    input  logic [width-1:0] in_packet,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [width-1:0] out_packet,
    output logic             empty,
    output logic             prog_full
);

    localparam int ptr_width   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_width = $clog2(depth + 1);

    logic [width-1:0]       mem [depth];
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] count;
    logic [count_width-1:0] count_next;
    logic                   push;
    logic                   pop;

    assign push = in_valid & in_ready;
    assign pop  = out_valid & out_ready;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    // ------------------------------
    // Pointers and occupancy
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_template_engine) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            // Ready tracks free space for the following cycle
            in_ready <= (count_next != count_width'(depth));
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_packet;
        end
    end

    // Head word shown as soon as it lands
    assign empty      = (count == '0);
    assign out_valid  = ~empty;
    assign out_packet = mem[rd_ptr];
    assign prog_full  = (count >= count_width'(prog_thresh));

endmodule

// ==== tb/engine_pipeline_assertions.sv ====
/*
 * Engine pipeline assertions
 * Stream stability, done exclusivity and reset values at the top level
 */
`timescale 1ns/1ps

module engine_pipeline_assertions (
    input logic                                ap_clk,
    input logic                                areset_template_engine,
    input logic                                response_engine_ready,
    input logic                                response_memory_ready,
    input logic                                request_engine_valid,
    input logic                                request_engine_ready,
    input engine_pipeline_pkg::engine_packet_t request_engine_packet,
    input logic                                request_memory_valid,
    input logic                                request_memory_ready,
    input engine_pipeline_pkg::memory_packet_t request_memory_packet,
    input logic                                done
);

    int failure_count = 0;

    // ------------------------------
    // Outputs held while stalled
    // ------------------------------
    engine_hold: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        request_engine_valid && !request_engine_ready
        |=> request_engine_valid && $stable(request_engine_packet))
    else begin
        failure_count++;
        $error("request_engine valid or packet changed while ready was low");
    end

    memory_hold: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        request_memory_valid && !request_memory_ready
        |=> request_memory_valid && $stable(request_memory_packet))
    else begin
        failure_count++;
        $error("request_memory valid or packet changed while ready was low");
    end

    // No completion while packets are still leaving
    done_exclusive: assert property (@(posedge ap_clk) disable iff (areset_template_engine)
        !(done && (request_engine_valid || request_memory_valid)))
    else begin
        failure_count++;
        $error("done high while an output valid is high");
    end

    reset_quiet: assert property (@(posedge ap_clk)
        areset_template_engine |=> !response_engine_ready && !response_memory_ready
            && !request_engine_valid && !request_memory_valid && !done)
    else begin
        failure_count++;
        $error("ready, valid or done output high after reset");
    end

endmodule

// ==== tb/engine_pipeline_patterns.hex ====
// Columns: channel tag (0 engine, 1 memory) _ id or address _ data word
// Engine ids sit in the low byte of the middle field
0_0001_0000a001
1_1000_c0de0001
0_0002_12345678
1_1004_deadbeef
1_1008_00000000
0_0003_ffffffff
0_0004_a5a5a5a5
1_100c_5a5a5a5a
0_0005_0badf00d
1_1010_ffffffff
1_ffff_13579bdf
0_00ff_2468ace0
0_0080_80000001
1_8000_7fffffff
0_0007_cafef00d
1_2222_01234567
0_0010_89abcdef
1_0001_feedface
0_0020_00c0ffee
1_abcd_11223344

// ==== tb/tb_engine_pipeline.sv ====
/*
 * Engine pipeline testbench
 * Pattern-driven traffic on both channels with random back-pressure and done checks
 */
`timescale 1ns/1ps

module tb_engine_pipeline;

    localparam int pattern_lines  = 20;
    localparam int timeout_cycles = 40 * pattern_lines + 200;
    localparam int stall_cycles   = 60;
    localparam int stall_rounds   = 4;

    logic                                ap_clk = 1'b0;
    logic                                areset_template_engine;
    logic                                descriptor_valid;
    logic                                response_engine_valid;
    logic                                response_engine_ready;
    engine_pipeline_pkg::engine_packet_t response_engine_packet;
    logic                                response_memory_valid;
    logic                                response_memory_ready;
    engine_pipeline_pkg::memory_packet_t response_memory_packet;
    logic                                request_engine_valid;
    logic                                request_engine_ready;
    engine_pipeline_pkg::engine_packet_t request_engine_packet;
    logic                                request_memory_valid;
    logic                                request_memory_ready;
    engine_pipeline_pkg::memory_packet_t request_memory_packet;
    logic                                done;

    // Channel tag in bits 51:48 and the packet below it
    logic [51:0] patterns [pattern_lines];

    engine_pipeline_pkg::engine_packet_t engine_send_q[$];
    engine_pipeline_pkg::engine_packet_t engine_expect_q[$];
    engine_pipeline_pkg::memory_packet_t memory_send_q[$];
    engine_pipeline_pkg::memory_packet_t memory_expect_q[$];

    logic [31:0] lcg_state;
    logic        memory_stall;
    logic        descriptor_seen;
    logic        memory_ready_fell;
    int          mismatch_errors;
    int          other_errors;
    int          cycle_count;

    engine_pipeline dut (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .descriptor_valid       (descriptor_valid),
        .response_engine_valid  (response_engine_valid),
        .response_engine_ready  (response_engine_ready),
        .response_engine_packet (response_engine_packet),
        .response_memory_valid  (response_memory_valid),
        .response_memory_ready  (response_memory_ready),
        .response_memory_packet (response_memory_packet),
        .request_engine_valid   (request_engine_valid),
        .request_engine_ready   (request_engine_ready),
        .request_engine_packet  (request_engine_packet),
        .request_memory_valid   (request_memory_valid),
        .request_memory_ready   (request_memory_ready),
        .request_memory_packet  (request_memory_packet),
        .done                   (done)
    );

    bind engine_pipeline engine_pipeline_assertions u_assertions (
        .ap_clk                 (ap_clk),
        .areset_template_engine (areset_template_engine),
        .response_engine_ready  (response_engine_ready),
        .response_memory_ready  (response_memory_ready),
        .request_engine_valid   (request_engine_valid),
        .request_engine_ready   (request_engine_ready),
        .request_engine_packet  (request_engine_packet),
        .request_memory_valid   (request_memory_valid),
        .request_memory_ready   (request_memory_ready),
        .request_memory_packet  (request_memory_packet),
        .done                   (done)
    );

    always #20 ap_clk = ~ap_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (actual !== expected) begin
            mismatch_errors++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // Queue every pattern of the chosen channels as stimulus and expected output
    task automatic load_round(input logic to_engine, input logic to_memory);
        logic [3:0] tag;
        for (int i = 0; i < pattern_lines; i++) begin
            tag = patterns[i][51:48];
            if (tag == 4'h0 && to_engine) begin
                engine_send_q.push_back(patterns[i][39:0]);
                engine_expect_q.push_back(patterns[i][39:0]);
            end else if (tag == 4'h1 && to_memory) begin
                memory_send_q.push_back(patterns[i][47:0]);
                memory_expect_q.push_back(patterns[i][47:0]);
            end else if (tag > 4'h1) begin
                other_errors++;
                $display("Pattern line %0d has unknown channel tag %0h", i, tag);
            end
        end
    endtask

    task automatic wait_for_drain();
        while (engine_expect_q.size() != 0 || memory_expect_q.size() != 0) begin
            @(negedge ap_clk);
        end
    endtask

    // ------------------------------
    // Sources
    // ------------------------------
    always @(posedge ap_clk) begin
        if (!areset_template_engine && (!response_engine_valid || response_engine_ready)) begin
            if (engine_send_q.size() != 0) begin
                response_engine_valid  <= 1'b1;
                response_engine_packet <= engine_send_q.pop_front();
            end else begin
                response_engine_valid <= 1'b0;
            end
        end
    end

    always @(posedge ap_clk) begin
        if (!areset_template_engine && (!response_memory_valid || response_memory_ready)) begin
            if (memory_send_q.size() != 0) begin
                response_memory_valid  <= 1'b1;
                response_memory_packet <= memory_send_q.pop_front();
            end else begin
                response_memory_valid <= 1'b0;
            end
        end
    end

    // Random sink back-pressure with an optional memory hold
    always @(posedge ap_clk) begin
        if (areset_template_engine) begin
            lcg_state            <= 32'd43975;
            request_engine_ready <= 1'b0;
            request_memory_ready <= 1'b0;
        end else begin
            lcg_state            <= lcg_next(lcg_state);
            request_engine_ready <= |lcg_state[30:29];
            request_memory_ready <= ~memory_stall & (|lcg_state[28:27]);
        end
    end

    // ------------------------------
    // Scoreboard
    // ------------------------------
    always @(posedge ap_clk) begin
        if (request_engine_valid && request_engine_ready) begin
            if (engine_expect_q.size() == 0) begin
                other_errors++;
                $display("Extra packet on request_engine after all expected ones arrived");
            end else begin
                check_value("request_engine_packet", request_engine_packet,
                            engine_expect_q.pop_front());
            end
        end
        if (request_memory_valid && request_memory_ready) begin
            if (memory_expect_q.size() == 0) begin
                other_errors++;
                $display("Extra packet on request_memory after all expected ones arrived");
            end else begin
                check_value("request_memory_packet", request_memory_packet,
                            memory_expect_q.pop_front());
            end
        end
    end

    always @(negedge ap_clk) begin
        if (!areset_template_engine) begin
            if (done && !descriptor_seen) begin
                other_errors++;
                $display("done went high before any descriptor was strobed");
            end
            if (memory_stall && !response_memory_ready) begin
                memory_ready_fell = 1'b1;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= timeout_cycles) begin
            $display("Run did not finish within %0d cycles", timeout_cycles);
            $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                     mismatch_errors, other_errors + 1, dut.u_assertions.failure_count);
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        areset_template_engine = 1'b1;
        descriptor_valid       = 1'b0;
        response_engine_valid  = 1'b0;
        response_engine_packet = '0;
        response_memory_valid  = 1'b0;
        response_memory_packet = '0;
        request_engine_ready   = 1'b0;
        request_memory_ready   = 1'b0;
        memory_stall           = 1'b0;
        descriptor_seen        = 1'b0;
        memory_ready_fell      = 1'b0;
        mismatch_errors        = 0;
        other_errors           = 0;
        cycle_count            = 0;
        $readmemh("tb/engine_pipeline_patterns.hex", patterns);

        repeat (5) @(posedge ap_clk);
        areset_template_engine <= 1'b0;
        @(posedge ap_clk);
        @(negedge ap_clk);
        check_value("request_engine_valid", request_engine_valid, 1'b0);
        check_value("request_memory_valid", request_memory_valid, 1'b0);
        check_value("done", done, 1'b0);
        check_value("response_engine_ready", response_engine_ready, 1'b1);
        check_value("response_memory_ready", response_memory_ready, 1'b1);

        // One round on both channels
        load_round(1'b1, 1'b1);
        wait_for_drain();

        // ------------------------------
        // Memory sink held while engine traffic completes
        @(posedge ap_clk);
        memory_stall <= 1'b1;
        @(negedge ap_clk);
        load_round(1'b1, 1'b0);
        repeat (stall_rounds) load_round(1'b0, 1'b1);
        repeat (stall_cycles) @(negedge ap_clk);
        if (engine_expect_q.size() != 0) begin
            other_errors++;
            $display("request_engine traffic stopped while request_memory was held");
        end
        if (!memory_ready_fell) begin
            other_errors++;
            $display("response_memory_ready never fell while request_memory was held");
        end
        @(posedge ap_clk);
        memory_stall <= 1'b0;
        wait_for_drain();

        // ------------------------------
        // Descriptor strobe then done until new work arrives
        @(posedge ap_clk);
        descriptor_valid <= 1'b1;
        descriptor_seen  <= 1'b1;
        @(posedge ap_clk);
        descriptor_valid <= 1'b0;
        while (!done) @(negedge ap_clk);
        repeat (10) begin
            @(negedge ap_clk);
            check_value("done", done, 1'b1);
        end
        load_round(1'b1, 1'b0);
        wait_for_drain();
        check_value("done", done, 1'b0);
        while (!done) @(negedge ap_clk);

        $display("Errors: %0d mismatches, %0d other, %0d assertion failures",
                 mismatch_errors, other_errors, dut.u_assertions.failure_count);
        if (mismatch_errors == 0 && other_errors == 0
                && dut.u_assertions.failure_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
